// File: synth_consts.svh
// Widths, table geometry and tuning constants shared by the synthesizer RTL and testbench
`ifndef SYNTH_CONSTS_SVH
`define SYNTH_CONSTS_SVH

// ----------------------------------------------------------------------
// Phase accumulator and tuning
// ----------------------------------------------------------------------
`define SYNTH_PHASE_W      32     // Full phase word
`define SYNTH_TUNE_W       18     // One bit per switch
`define SYNTH_TUNE_SHIFT   14     // Switch value to phase step

// ----------------------------------------------------------------------
// Sine table
// ----------------------------------------------------------------------
`define SYNTH_SAMPLE_W     16     // Two's complement sample
`define SYNTH_INDEX_W      8      // Top bits of the phase
`define SYNTH_TABLE_DEPTH  256    // One full turn
`define SYNTH_QUAD_OFFSET  64     // Quarter turn for the 90 degree output

// Peak of the table, 2^14 - 1
`define SYNTH_AMPLITUDE    16383

`endif

// File: synth_pkg.sv
// Types for phase, sample and tuning values, imported by the synthesizer RTL modules
`default_nettype none
`include "synth_consts.svh"

package synth_pkg;

   // Table address
   typedef logic [`SYNTH_INDEX_W-1:0] table_index_t;

   // Signed audio sample
   typedef logic signed [`SYNTH_SAMPLE_W-1:0] sample_t;

   // Raw switch setting
   typedef logic [`SYNTH_TUNE_W-1:0] tune_t;

   // Phase word
   // Added as a plain number, split into index and fraction for lookup
   typedef union packed {
      logic [`SYNTH_PHASE_W-1:0] raw;                      // Accumulator view
      struct packed {
         table_index_t                              index;  // Table address
         logic [`SYNTH_PHASE_W-`SYNTH_INDEX_W-1:0]  frac;   // Dropped on lookup
      } f;
   } phase_u;

endpackage

`default_nettype wire

// File: sine_bus_if.sv
// APB read bus from a DDS voice or the arbiter to the sine table, one per link
`timescale 1ns/1ns
`default_nettype none
`include "synth_consts.svh"

interface sine_bus_if ();

   logic                        psel;     // Transfer selected
   logic                        penable;  // Access phase
   logic [`SYNTH_INDEX_W-1:0]   paddr;    // Table index, held until pready
   logic [`SYNTH_SAMPLE_W-1:0]  prdata;   // Entry, valid with pready
   logic                        pready;   // Access completes

   // Requesting side
   modport master (
      output psel,
      output penable,
      output paddr,
      input  prdata,
      input  pready
   );

   // Answering side
   modport slave (
      input  psel,
      input  penable,
      input  paddr,
      output prdata,
      output pready
   );

endinterface

`default_nettype wire

// File: tune_control.sv
// Switch and save key front end, gives the live and the saved phase steps to the voices
`timescale 1ns/1ns
`default_nettype none
`include "synth_consts.svh"

module tune_control (
   input  wire logic                 AUD_DACLRCK,
   input  wire logic                 rst,
   input  wire synth_pkg::tune_t     sw,
   input  wire logic                 save_n,
   output synth_pkg::phase_u         tune_live,
   output synth_pkg::phase_u         tune_saved
);
   import synth_pkg::*;

   tune_t sw_meta;    // First synchronizer stage
   tune_t sw_q;       // Safe switch value
   logic  key_meta;
   logic  key_q;
   logic  key_prev;   // For edge detect
   logic  press;

   // ----------------------------------------------------------------------
   // Two-flop synchronizers
   // ----------------------------------------------------------------------
   always_ff @(posedge AUD_DACLRCK or negedge rst) begin
      if (!rst) begin
         sw_meta  <= '0;
         sw_q     <= '0;
         key_meta <= 1'b1;    // Key released
         key_q    <= 1'b1;
         key_prev <= 1'b1;
      end else begin
         sw_meta  <= sw;
         sw_q     <= sw_meta;
         key_meta <= save_n;
         key_q    <= key_meta;
         key_prev <= key_q;
      end
   end

   // Falling edge of the active-low key
   assign press = key_prev && !key_q;

   // Phase step is the switch value moved up into the top bits
   assign tune_live.raw = {sw_q, {`SYNTH_TUNE_SHIFT{1'b0}}};

   // Saved voice stays silent until the first press
   always_ff @(posedge AUD_DACLRCK or negedge rst) begin
      if (!rst) begin
         tune_saved <= '0;
      end else if (press) begin
         tune_saved <= tune_live;    // Grab the pitch being played
      end
   end

   // Saved pitch moves only right after a key press
   a_saved_on_press: assert property (@(posedge AUD_DACLRCK) disable iff (!rst)
      $changed(tune_saved.raw) |-> $past(press));

endmodule

`default_nettype wire

// File: dds_voice.sv
// One DDS voice, reads sine and quadrature from the shared table once per sample
`timescale 1ns/1ns
`default_nettype none
`include "synth_consts.svh"

module dds_voice (
   input  wire logic                 AUD_DACLRCK,
   input  wire logic                 rst,
   input  wire synth_pkg::phase_u    tune,
   sine_bus_if.master                bus,
   output synth_pkg::sample_t        sine,
   output synth_pkg::sample_t        quad,
   output logic                      valid
);
   import synth_pkg::*;

   // Sequencer states
   localparam logic [2:0] S_IDLE        = 3'd0;   // One cycle out of reset
   localparam logic [2:0] S_SIN_SETUP   = 3'd1;
   localparam logic [2:0] S_SIN_ACCESS  = 3'd2;
   localparam logic [2:0] S_QUAD_SETUP  = 3'd3;
   localparam logic [2:0] S_QUAD_ACCESS = 3'd4;

   logic [2:0]   state_q;
   phase_u       phase_q;      // Accumulated phase
   sample_t      sine_hold;    // Sine result waiting for its quadrature partner
   table_index_t quad_index;
   logic         quad_read;    // Second read of the sample

   // Quarter turn ahead, wraps around the table
   assign quad_index = phase_q.f.index + table_index_t'(`SYNTH_QUAD_OFFSET);
   assign quad_read  = (state_q == S_QUAD_SETUP) || (state_q == S_QUAD_ACCESS);

   // ----------------------------------------------------------------------
   // APB master signals
   // ----------------------------------------------------------------------
   assign bus.psel    = (state_q != S_IDLE);
   assign bus.penable = (state_q == S_SIN_ACCESS) || (state_q == S_QUAD_ACCESS);
   assign bus.paddr   = quad_read ? quad_index : phase_q.f.index;

   always_ff @(posedge AUD_DACLRCK or negedge rst) begin
      if (!rst) begin
         state_q <= S_IDLE;
         phase_q <= '0;
         sine    <= '0;
         quad    <= '0;
         valid   <= 1'b0;
      end else begin
         valid <= 1'b0;    // Single-cycle pulse
         case (state_q)
            S_IDLE:       state_q <= S_SIN_SETUP;
            S_SIN_SETUP:  state_q <= S_SIN_ACCESS;
            S_SIN_ACCESS: if (bus.pready) state_q <= S_QUAD_SETUP;   // Waits out the arbiter
            S_QUAD_SETUP: state_q <= S_QUAD_ACCESS;
            S_QUAD_ACCESS: begin
               if (bus.pready) begin
                  sine          <= sine_hold;
                  quad          <= bus.prdata;
                  valid         <= 1'b1;
                  phase_q.raw   <= phase_q.raw + tune.raw;   // Step for the next sample
                  state_q       <= S_SIN_SETUP;
               end
            end
            default:      state_q <= S_IDLE;
         endcase
      end
   end

   // Holding register for the first read
   always_ff @(posedge AUD_DACLRCK) begin
      if ((state_q == S_SIN_ACCESS) && bus.pready) begin
         sine_hold <= bus.prdata;
      end
   end

   // Access only inside a selected transfer
   a_penable_psel: assert property (@(posedge AUD_DACLRCK) disable iff (!rst)
      bus.penable |-> bus.psel);

   // Address held until the table answers
   a_paddr_hold: assert property (@(posedge AUD_DACLRCK) disable iff (!rst)
      (bus.psel && !bus.pready) |=> $stable(bus.paddr));

endmodule

`default_nettype wire

// File: sine_rom_arbiter.sv
// Round-robin arbiter putting the two voice buses onto the single sine table bus
`timescale 1ns/1ns
`default_nettype none

module sine_rom_arbiter (
   input  wire logic   AUD_DACLRCK,
   input  wire logic   rst,
   sine_bus_if.slave   live_bus,
   sine_bus_if.slave   saved_bus,
   sine_bus_if.master  rom_bus
);
   import synth_pkg::*;

   logic         busy_q;      // Transfer locked onto the table
   logic         grant_q;     // High when the saved voice owns the table
   logic         last_q;      // Voice served most recently
   logic         req_live;
   logic         req_saved;
   logic         pick;        // Winner for a new transfer
   logic         sel;         // Voice routed this cycle
   table_index_t sel_addr;

   assign req_live  = live_bus.psel;
   assign req_saved = saved_bus.psel;

   // Alternate on a tie, otherwise whoever asks
   assign pick = (req_live && req_saved) ? !last_q : req_saved;
   assign sel  = busy_q ? grant_q : pick;

   assign sel_addr = sel ? saved_bus.paddr : live_bus.paddr;

   // ----------------------------------------------------------------------
   // Table side
   // ----------------------------------------------------------------------
   // Idle cycle with a request is the setup, locked cycle is the access
   assign rom_bus.psel    = busy_q || req_live || req_saved;
   assign rom_bus.penable = busy_q;
   assign rom_bus.paddr   = sel_addr;

   // Answer goes back to the owner only
   assign live_bus.pready  = busy_q && !grant_q && rom_bus.pready;
   assign saved_bus.pready = busy_q && grant_q && rom_bus.pready;
   assign live_bus.prdata  = (busy_q && !grant_q) ? rom_bus.prdata : '0;
   assign saved_bus.prdata = (busy_q && grant_q) ? rom_bus.prdata : '0;

   always_ff @(posedge AUD_DACLRCK or negedge rst) begin
      if (!rst) begin
         busy_q  <= 1'b0;
         grant_q <= 1'b0;
         last_q  <= 1'b1;    // Live voice wins the first tie
      end else if (!busy_q) begin
         if (req_live || req_saved) begin
            busy_q  <= 1'b1;
            grant_q <= pick;
         end
      end else if (rom_bus.pready) begin
         busy_q <= 1'b0;     // Free for the next setup
         last_q <= grant_q;
      end
   end

   // Only one voice completes per cycle
   a_one_ready: assert property (@(posedge AUD_DACLRCK) disable iff (!rst)
      !(live_bus.pready && saved_bus.pready));

endmodule

`default_nettype wire

// File: sine_rom.sv
// Sine table computed at elaboration, answers APB reads with a registered entry
`timescale 1ns/1ns
`default_nettype none
`include "synth_consts.svh"

module sine_rom (
   input  wire logic   AUD_DACLRCK,
   input  wire logic   rst,
   sine_bus_if.slave   bus
);
   import synth_pkg::*;

   localparam real TWO_PI = 6.283185307179586;

   sample_t sine_table [`SYNTH_TABLE_DEPTH];
   sample_t rdata_q;     // Entry for the pending read
   logic    ready_q;     // Setup seen last cycle

   // One full period, truncated toward zero
   initial begin
      for (int i = 0; i < `SYNTH_TABLE_DEPTH; i++) begin
         sine_table[i] = sample_t'($rtoi(`SYNTH_AMPLITUDE *
                                         $sin(TWO_PI * i / `SYNTH_TABLE_DEPTH)));
      end
   end

   // ----------------------------------------------------------------------
   // Read port
   // ----------------------------------------------------------------------
   always_ff @(posedge AUD_DACLRCK) begin
      if (bus.psel && !bus.penable) begin
         rdata_q <= sine_table[bus.paddr];   // Address taken at setup
      end
   end

   always_ff @(posedge AUD_DACLRCK or negedge rst) begin
      if (!rst) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= bus.psel && !bus.penable;
      end
   end

   assign bus.prdata = rdata_q;
   assign bus.pready = ready_q;   // Never stalls the access

endmodule

`default_nettype wire

// File: synth_top.sv
// Top of the two-voice DDS synthesizer, switches and save key in, parallel samples out
`timescale 1ns/1ns
`default_nettype none

module synth_top (
   input  wire logic              AUD_DACLRCK,   // Audio sample clock
   input  wire logic              rst,
   input  wire synth_pkg::tune_t  sw,            // Live pitch
   input  wire logic              save_n,        // Save key, pressed low
   output synth_pkg::sample_t     live_sine,
   output synth_pkg::sample_t     live_quad,
   output logic                   live_valid,
   output synth_pkg::sample_t     saved_sine,
   output synth_pkg::sample_t     saved_quad,
   output logic                   saved_valid
);
   import synth_pkg::*;

   phase_u tune_live;    // Step from the switches
   phase_u tune_saved;   // Step captured by the key

   sine_bus_if live_bus ();
   sine_bus_if saved_bus ();
   sine_bus_if rom_bus ();

   // ----------------------------------------------------------------------
   // Tuning
   // ----------------------------------------------------------------------
   tune_control u_tune (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .sw          (sw),
      .save_n      (save_n),
      .tune_live   (tune_live),
      .tune_saved  (tune_saved)
   );

   // ----------------------------------------------------------------------
   // Voices
   // ----------------------------------------------------------------------
   dds_voice u_live_voice (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .tune        (tune_live),
      .bus         (live_bus),
      .sine        (live_sine),
      .quad        (live_quad),
      .valid       (live_valid)
   );

   dds_voice u_saved_voice (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .tune        (tune_saved),
      .bus         (saved_bus),
      .sine        (saved_sine),
      .quad        (saved_quad),
      .valid       (saved_valid)
   );

   // Shared table behind the arbiter
   sine_rom_arbiter u_arbiter (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .live_bus    (live_bus),
      .saved_bus   (saved_bus),
      .rom_bus     (rom_bus)
   );

   sine_rom u_rom (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .bus         (rom_bus)
   );

endmodule

`default_nettype wire

// File: synth_tb.sv
// Testbench for the two-voice synthesizer, replays the trace file and checks every sample
`timescale 1ns/1ns
`default_nettype none
`include "synth_consts.svh"

module synth_tb;

   localparam real TWO_PI      = 6.283185307179586;
   localparam int  TRACE_WORDS = 256;
   localparam int  STALL_LIMIT = 32;    // Cycles without a sample before a voice is stuck

   logic                        AUD_DACLRCK = 1'b0;
   logic                        rst;
   logic [`SYNTH_TUNE_W-1:0]    sw;
   logic                        save_n;
   logic [`SYNTH_SAMPLE_W-1:0]  live_sine;
   logic [`SYNTH_SAMPLE_W-1:0]  live_quad;
   logic                        live_valid;
   logic [`SYNTH_SAMPLE_W-1:0]  saved_sine;
   logic [`SYNTH_SAMPLE_W-1:0]  saved_quad;
   logic                        saved_valid;

   logic [`SYNTH_SAMPLE_W-1:0]  model_table [`SYNTH_TABLE_DEPTH];
   logic [31:0]                 trace [TRACE_WORDS];
   logic [`SYNTH_TUNE_W-1:0]    sw_hist1;       // Switch seen one edge ago
   logic [`SYNTH_TUNE_W-1:0]    sw_hist2;       // Two edges ago, what the voice adds
   logic [`SYNTH_PHASE_W-1:0]   step_at_edge;   // Live step used at the last rising edge
   int                          errors      = 0;
   int                          checks      = 0;
   int                          cycle_count = 0;
   int                          cycle_limit = 0;

   always #10 AUD_DACLRCK = ~AUD_DACLRCK;   // 20 ns period

   synth_top UUT (
      .AUD_DACLRCK (AUD_DACLRCK),
      .rst         (rst),
      .sw          (sw),
      .save_n      (save_n),
      .live_sine   (live_sine),
      .live_quad   (live_quad),
      .live_valid  (live_valid),
      .saved_sine  (saved_sine),
      .saved_quad  (saved_quad),
      .saved_valid (saved_valid)
   );

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------
   // Switch changes reach the live step two edges late
   always @(posedge AUD_DACLRCK) begin
      if (!rst) begin
         sw_hist1     <= '0;
         sw_hist2     <= '0;
         step_at_edge <= '0;
      end else begin
         step_at_edge <= {sw_hist2, {`SYNTH_TUNE_SHIFT{1'b0}}};
         sw_hist2     <= sw_hist1;
         sw_hist1     <= sw;
      end
   end

   // Run limit from the trace lengths
   always @(posedge AUD_DACLRCK) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count > cycle_limit) begin
         $display("Timeout, no end of test after %0d cycles", cycle_count);
         $display("Checks run: %0d, errors: %0d", checks, errors);
         $display("TEST FAILED");
         $finish;
      end
   end

   // Amplitude times sine of the turn fraction, truncated toward zero
   task automatic build_table();
      for (int i = 0; i < `SYNTH_TABLE_DEPTH; i++) begin
         model_table[i] = 16'($rtoi(`SYNTH_AMPLITUDE *
                                    $sin(TWO_PI * i / `SYNTH_TABLE_DEPTH)));
      end
   endtask

   task automatic check_sample(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("[ERROR] %s: got %h, expected %h at %0t", name, got, expected, $time);
      end
   endtask

   // Sine at the phase index, quadrature a quarter turn on
   task automatic check_pair(input string voice, input logic [15:0] got_sine,
                             input logic [15:0] got_quad, input logic [31:0] phase);
      logic [`SYNTH_INDEX_W-1:0] index;
      logic [`SYNTH_INDEX_W-1:0] quad_index;
      index      = phase[`SYNTH_PHASE_W-1 -: `SYNTH_INDEX_W];
      quad_index = index + 8'(`SYNTH_QUAD_OFFSET);
      check_sample({voice, "_sine"}, got_sine, model_table[index]);
      check_sample({voice, "_quad"}, got_quad, model_table[quad_index]);
   endtask

   task automatic apply_reset(input logic [`SYNTH_TUNE_W-1:0] item_sw);
      @(negedge AUD_DACLRCK);
      rst    = 1'b0;
      sw     = item_sw;
      save_n = 1'b1;
      repeat (2) @(negedge AUD_DACLRCK);
      rst = 1'b1;
   endtask

   // ----------------------------------------------------------------------
   // One trace item
   // ----------------------------------------------------------------------
   task automatic run_item(input logic [`SYNTH_TUNE_W-1:0] item_sw, input logic save,
                           input int count);
      logic [31:0] live_phase;
      logic [31:0] saved_phase;
      logic [31:0] saved_step;
      logic        pressed;
      logic        aligned;
      logic        moved;
      int          live_done;
      int          saved_done;
      int          live_gap;
      int          saved_gap;
      int          key_hold;
      live_phase  = '0;
      saved_phase = '0;
      saved_step  = {14'b0, item_sw} << `SYNTH_TUNE_SHIFT;
      pressed     = 1'b0;
      aligned     = 1'b0;
      moved       = 1'b0;
      live_done   = 0;
      saved_done  = 0;
      live_gap    = 0;
      saved_gap   = 0;
      key_hold    = 0;
      $display("Item: switch %h, save %0d, %0d samples", item_sw, save, count);
      apply_reset(item_sw);
      while (live_done < count || (save && saved_done < count)) begin
         @(negedge AUD_DACLRCK);
         // Live voice, exact phase from reset
         if (live_valid) begin
            check_pair("live", live_sine, live_quad, live_phase);
            live_phase = live_phase + step_at_edge;
            live_done++;
            live_gap = 0;
         end else begin
            live_gap++;
         end
         if (saved_valid) begin
            saved_gap = 0;
            if (!pressed) begin
               check_sample("saved_sine", saved_sine, 16'h0000);
               check_sample("saved_quad", saved_quad, model_table[`SYNTH_QUAD_OFFSET]);
            end else if (aligned || saved_sine != 16'h0000 ||
                         saved_quad != model_table[`SYNTH_QUAD_OFFSET]) begin
               if (!aligned) saved_phase = saved_step;   // First step after capture
               aligned = 1'b1;
               check_pair("saved", saved_sine, saved_quad, saved_phase);
               saved_phase = saved_phase + saved_step;
               saved_done++;
            end
         end else begin
            saved_gap++;
         end
         if (live_gap > STALL_LIMIT || saved_gap > STALL_LIMIT) begin
            errors++;
            $display("A voice produced no sample for %0d cycles at %0t", STALL_LIMIT, $time);
            live_gap  = 0;
            saved_gap = 0;
         end
         // Key press early on, held for a few cycles
         if (save && !pressed && live_done >= 2) begin
            save_n   = 1'b0;
            pressed  = 1'b1;
            key_hold = 4;
         end else if (key_hold > 0) begin
            key_hold--;
            if (key_hold == 0) save_n = 1'b1;
         end
         // New live pitch halfway through the saved run
         if (aligned && !moved && saved_done >= count / 2) begin
            sw    = item_sw + 18'h00c00;
            moved = 1'b1;
         end
      end
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial begin
      int pos;
      int items;
      int limit;
      rst    = 1'b0;
      sw     = '0;
      save_n = 1'b1;
      items  = 0;
      limit  = 100;
      $readmemh("synth_trace.txt", trace);
      build_table();

      // Spot checks and the run limit
      pos = 0;
      while (pos + 3 < TRACE_WORDS && trace[pos] != 32'd0) begin
         if (trace[pos] == 32'd1) begin
            checks++;
            if (model_table[trace[pos+1][7:0]] !== trace[pos+2][15:0]) begin
               errors++;
               $display("[ERROR] model_table[%h]: got %h, expected %h", trace[pos+1][7:0],
                        model_table[trace[pos+1][7:0]], trace[pos+2][15:0]);
            end
         end else if (trace[pos] == 32'd2) begin
            limit = limit + int'(trace[pos+3]) * 10 + 64;
            items++;
         end else begin
            errors++;
            $display("Trace record at word %0d has an unknown kind %0d", pos, trace[pos]);
         end
         pos += 4;
      end
      cycle_limit = limit;
      if (items == 0) begin
         errors++;
         $display("Trace file holds no stimulus items");
      end

      pos = 0;
      while (pos + 3 < TRACE_WORDS && trace[pos] != 32'd0) begin
         if (trace[pos] == 32'd2) begin
            run_item(trace[pos+1][`SYNTH_TUNE_W-1:0], trace[pos+2][0], int'(trace[pos+3]));
         end
         pos += 4;
      end

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: synth_top.f
+incdir+.
synth_pkg.sv
sine_bus_if.sv
tune_control.sv
dds_voice.sv
sine_rom_arbiter.sv
sine_rom.sv
synth_top.sv
synth_tb.sv

// File: Makefile
# Verilator build and run of the synthesizer testbench
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ns
TOP       := synth_tb
FILELIST  := synth_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_TEXT := TEST PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: synth_trace.txt
// Four hex fields per record: kind, a, b, c
// kind 1 spot check (a index, b entry); kind 2 item (a switch, b save flag, c samples); 0 ends
1 00 0000 0
1 20 2d40 0
1 40 3fff 0
1 80 0000 0
1 c0 c001 0
1 e0 d2c0 0
// Live voice only, saved voice must stay silent
2 00400 0 18
2 01a2b 0 20
2 3ffff 0 18
// Save key pressed, switches moved afterwards
2 05555 1 30
2 12345 1 40
2 2c001 1 28
0 0 0 0
